// ==== Makefile ====
# Verilator build of the SPU lane testbench, rebuilt only when a source changes

SOURCES := $(shell cat sources.f)

all: run

obj_dir/spu_tb: sources.f $(SOURCES)
	verilator --binary --timing --assert --top-module spu_tb -Mdir obj_dir -o spu_tb -f sources.f

run: obj_dir/spu_tb
	-./obj_dir/spu_tb > sim.log 2>&1
	cat sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== dv/spu_asserts.sv ====
`timescale 1ns/1ps

module spu_asserts (
    input logic             clk,
    input logic             rst,
    input logic             cke,
    input spu_pkg::spu_op_t s_op,
    input logic             s_clear,
    input logic             s_valid,
    input spu_pkg::data_t   m_data,
    input logic             m_carry,
    input logic             m_valid,
    input logic             logic_valid
);

    import spu_pkg::*;

    logic [LANE_LATENCY-1:0] valid_track;     // accepted strobes shifted per enabled edge
    logic [LANE_LATENCY-1:0] no_carry_track;  // items owed carry 0
    logic                    item_no_carry;
    int                      assert_errors = 0;  // read by the testbench at the end

    // logic ops, cleared items and unused codes all leave carry low
    assign item_no_carry = s_clear || (s_op != OP_ADD && s_op != OP_SUB);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_track    <= '0;
            no_carry_track <= '0;
        end else if (cke) begin
            valid_track    <= {valid_track[LANE_LATENCY-2:0], s_valid};
            no_carry_track <= {no_carry_track[LANE_LATENCY-2:0], item_no_carry};
        end
    end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        m_valid == valid_track[LANE_LATENCY-1])
        else begin
            $error("m_valid not two enabled edges after its strobe");
            assert_errors++;
        end

    a_reset: assert property (@(posedge clk) rst |=> !m_valid)
        else begin
            $error("m_valid high right after reset");
            assert_errors++;
        end

    a_logic_carry: assert property (@(posedge clk) disable iff (rst)
        (m_valid && no_carry_track[LANE_LATENCY-1]) |-> !m_carry)
        else begin
            $error("m_carry set on a logic result");
            assert_errors++;
        end

    // frozen lane
    a_hold: assert property (@(posedge clk) disable iff (rst)
        !cke |=> ($stable(m_data) && $stable(m_carry) && $stable(m_valid)))
        else begin
            $error("outputs moved while cke low");
            assert_errors++;
        end

    a_branch_align: assert property (@(posedge clk) disable iff (rst)
        logic_valid == m_valid)
        else begin
            $error("logic and add/sub branches out of step");
            assert_errors++;
        end

endmodule

bind spu_core spu_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .cke         (cke),
    .s_op        (s_op),
    .s_clear     (s_clear),
    .s_valid     (s_valid),
    .m_data      (m_data),
    .m_carry     (m_carry),
    .m_valid     (m_valid),
    .logic_valid (logic_valid)
);

// ==== dv/spu_clk_gen.sv ====
`timescale 1ns/1ps

module spu_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 10;  // 20 ns clock
    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;  // last reset edge still sees rst high
    end

endmodule

// ==== dv/spu_input.txt ====
# columns: test op data0 data1 clear exp_data exp_carry (data columns hex)
# op: 0 nor, 1 and, 2 or, 3 xor, 4 add, 5 sub, 6 and 7 unused
1 0 0000 0000 0 ffff 0
1 0 ffff ffff 0 0000 0
1 0 00ff 0f0f 0 f000 0
1 1 a5a5 0ff0 0 05a0 0
1 2 a5a5 0ff0 0 aff5 0
1 3 a5a5 0ff0 0 aa55 0
1 3 ffff 5555 0 aaaa 0
2 4 1234 4321 0 5555 0
2 4 ffff 0001 0 0000 1
2 4 7fff 0001 0 8000 0
2 4 f000 1234 0 0234 1
2 5 5555 1234 0 4321 1
2 5 1234 5555 0 bcdf 0
2 5 7fff 7fff 0 0000 1
3 4 ffff 0001 1 0000 0
3 0 0000 0000 1 0000 0
3 6 1234 5678 0 0000 0
3 7 ffff ffff 0 0000 0
3 3 1234 5678 1 0000 0
4 4 0001 0002 0 0003 0
4 1 f0f0 ff00 0 f000 0
4 5 0010 0001 0 000f 1
4 2 0f00 00f0 0 0ff0 0
4 4 8001 8001 0 0002 1
4 0 f0f0 0f00 0 000f 0
5 4 aaaa 5555 0 ffff 0
5 0 aaaa 5555 0 0000 0
5 5 aaaa 5555 0 5555 1
5 1 3c3c 00ff 0 003c 0
5 6 0000 0000 0 0000 0
5 3 3c3c c3c3 0 ffff 0
5 5 0001 0100 0 ff01 0

// ==== dv/spu_tb.sv ====
`timescale 1ns/1ps

module spu_tb;

    import spu_pkg::*;

    localparam int          STREAM_TEST = 4;  // sent back to back without gaps
    localparam int          DRAIN_LIMIT = 10;
    localparam int          RESET_LIMIT = 10;
    localparam int          TAIL_CYCLES = 6;
    localparam logic [31:0] LFSR_SEED   = 32'h588e_3b95;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic    clk;
    logic    rst;
    logic    cke;
    spu_op_t s_op;
    data_t   s_data0;
    data_t   s_data1;
    logic    s_clear;
    logic    s_valid;
    data_t   m_data;
    logic    m_carry;
    logic    m_valid;

    int         vec_test  [$];
    logic [2:0] vec_op    [$];
    data_t      vec_d0    [$];
    data_t      vec_d1    [$];
    logic       vec_clr   [$];
    data_t      vec_exp_d [$];
    logic       vec_exp_c [$];

    data_t exp_data_q  [$];  // results still owed in strobe order
    logic  exp_carry_q [$];

    logic [31:0] lfsr_state;
    logic        last_cke;  // cke seen by the edge just past
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          strobe_count;
    int          valid_count;

    spu_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    spu_core UUT (
        .clk     (clk),
        .rst     (rst),
        .cke     (cke),
        .s_op    (s_op),
        .s_data0 (s_data0),
        .s_data1 (s_data1),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (m_data),
        .m_carry (m_carry),
        .m_valid (m_valid)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
        return val;
    endfunction

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_carry(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_valid(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    t;
        int    op;
        int    d0;
        int    d1;
        int    clr;
        int    ed;
        int    ec;
        string line;
        fd = $fopen("dv/spu_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open dv/spu_input.txt");
            test_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;  // blank or column notes
            if ($sscanf(line, "%d %d %h %h %d %h %d", t, op, d0, d1, clr, ed, ec) != 7) begin
                $display("ERROR: malformed vector line: %s", line);
                test_errors++;
            end else begin
                vec_test.push_back(t);
                vec_op.push_back(3'(op));
                vec_d0.push_back(data_t'(d0));
                vec_d1.push_back(data_t'(d1));
                vec_clr.push_back(clr != 0);
                vec_exp_d.push_back(data_t'(ed));
                vec_exp_c.push_back(ec != 0);
            end
        end
        $fclose(fd);
        if (vec_op.size() == 0) begin
            $display("ERROR: no vectors found in dv/spu_input.txt");
            test_errors++;
        end
    endtask

    // one result per enabled edge with m_valid high
    task automatic collect_output();
        data_t exp_d;
        logic  exp_c;
        if (last_cke && m_valid) begin
            valid_count++;
            if (exp_data_q.size() == 0) begin
                $display("ERROR: m_valid raised at %0t ns with no result pending", $time);
                test_errors++;
            end else begin
                exp_d = exp_data_q.pop_front();
                exp_c = exp_carry_q.pop_front();
                check_data("m_data", m_data, exp_d);
                check_carry("m_carry", m_carry, exp_c);
            end
        end
    endtask

    // vi below zero leaves s_valid low
    task automatic next_cycle(input logic cke_v, input int vi);
        @(negedge clk);
        collect_output();
        cke = cke_v;
        if (vi >= 0) begin
            s_valid = 1'b1;
            s_op    = spu_op_t'(vec_op[vi]);
            s_data0 = vec_d0[vi];
            s_data1 = vec_d1[vi];
            s_clear = vec_clr[vi];
            exp_data_q.push_back(vec_exp_d[vi]);
            exp_carry_q.push_back(vec_exp_c[vi]);
            strobe_count++;
        end else begin
            s_valid = 1'b0;
        end
        last_cke = cke_v;
    endtask

    task automatic send_item(input int vi, input logic stream);
        int   gap;
        logic spaced;
        gap    = 0;
        spaced = 1'b0;
        if (!stream) begin
            gap    = random_bits(2);       // 0 to 3 frozen cycles
            spaced = random_bits(1) != 0;  // idle cycle after the strobe
        end
        for (int g = 0; g < gap; g++) begin
            next_cycle(1'b0, -1);
        end
        next_cycle(1'b1, vi);
        if (spaced) next_cycle(1'b1, -1);
    endtask

    task automatic drain_results(input int test_num);
        int n;
        n = 0;
        while (exp_data_q.size() > 0 && n < DRAIN_LIMIT) begin
            next_cycle(1'b1, -1);
            n++;
        end
        if (exp_data_q.size() > 0) begin
            $display("ERROR: timeout, %0d results of test %0d never appeared on m_valid",
                     exp_data_q.size(), test_num);
            test_errors++;
            exp_data_q.delete();
            exp_carry_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL (%0d errors)", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int   vi;
        int   cur_test;
        int   n;
        logic stream;

        cke          = 1'b1;
        s_op         = OP_NOR;
        s_data0      = '0;
        s_data1      = '0;
        s_clear      = 1'b0;
        s_valid      = 1'b0;
        lfsr_state   = LFSR_SEED;
        last_cke     = 1'b1;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        strobe_count = 0;
        valid_count  = 0;

        load_vectors();
        finish_test("vector load");

        n = 0;
        while (rst && n < RESET_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            $display("ERROR: reset was never released");
            test_errors++;
        end
        check_valid("m_valid", m_valid, 1'b0);
        check_data("m_data", m_data, 16'h0000);
        check_carry("m_carry", m_carry, 1'b0);
        finish_test("reset");

        vi = 0;
        while (vi < vec_op.size()) begin
            cur_test = vec_test[vi];
            stream   = (cur_test == STREAM_TEST);
            while (vi < vec_op.size() && vec_test[vi] == cur_test) begin
                send_item(vi, stream);
                vi++;
            end
            drain_results(cur_test);
            finish_test($sformatf("test %0d", cur_test));
        end

        // late or doubled m_valid shows up here
        repeat (TAIL_CYCLES) next_cycle(1'b1, -1);
        if (valid_count != strobe_count) begin
            $display("ERROR: %0d m_valid pulses for %0d strobes", valid_count, strobe_count);
            test_errors++;
        end
        if (UUT.u_asserts.assert_errors != 0) begin
            $display("ERROR: %0d bound assertion checks failed during the run",
                     UUT.u_asserts.assert_errors);
            test_errors++;
        end
        finish_test("tail");

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== hw/spu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module spu_core (
    input  var logic             clk,
    input  var logic             rst,
    input  var logic             cke,

    input  var spu_pkg::spu_op_t s_op,
    input  var spu_pkg::data_t   s_data0,
    input  var spu_pkg::data_t   s_data1,
    input  var logic             s_clear,
    input  var logic             s_valid,

    output var spu_pkg::data_t   m_data,
    output var logic             m_carry,
    output var logic             m_valid
);

    import spu_pkg::*;

    logic_func_t logic_func;
    logic        is_sub;
    logic        unused_op;
    logic        item_clear;

    data_t       logic_data;
    logic        logic_raw_valid;
    data_t       logic_pad_data;
    logic        logic_valid;    // watched by the bound checks

    data_t       as_data;
    logic        as_carry;

    spu_op_t     tag_op;

    // op decode
    always_comb begin
        logic_func = LF_NOR;
        is_sub     = 1'b0;
        unused_op  = 1'b0;
        case (s_op)
            OP_NOR:  logic_func = LF_NOR;
            OP_AND:  logic_func = LF_AND;
            OP_OR:   logic_func = LF_OR;
            OP_XOR:  logic_func = LF_XOR;
            OP_ADD:  is_sub = 1'b0;
            OP_SUB:  is_sub = 1'b1;
            default: unused_op = 1'b1;  // codes 6 and 7
        endcase
    end

    // unused codes ride through as cleared items
    assign item_clear = s_clear | unused_op;

    spu_op_logic u_logic (
        .clk     (clk),
        .rst     (rst),
        .cke     (cke),
        .s_func  (logic_func),
        .s_data0 (s_data0),
        .s_data1 (s_data1),
        .s_clear (item_clear),
        .s_valid (s_valid),
        .m_data  (logic_data),
        .m_valid (logic_raw_valid)
    );

    // pad logic branch up to the add/sub depth
    spu_op_delay #(
        .LATENCY    (LANE_LATENCY - LOGIC_LATENCY),
        .data_t     (data_t),
        .CLEAR_DATA (CLEAR_WORD)
    ) u_logic_pad (
        .clk     (clk),
        .rst     (rst),
        .cke     (cke),
        .s_data  (logic_data),
        .s_clear (1'b0),
        .s_valid (logic_raw_valid),
        .m_data  (logic_pad_data),
        .m_valid (logic_valid)
    );

    spu_op_addsub u_addsub (
        .clk     (clk),
        .rst     (rst),
        .cke     (cke),
        .s_sub   (is_sub),
        .s_data0 (s_data0),
        .s_data1 (s_data1),
        .s_clear (item_clear),
        .s_valid (s_valid),
        .m_data  (as_data),
        .m_carry (as_carry),
        .m_valid (m_valid)
    );

    // a cleared item's tag turns into OP_NOR, so the zeroed logic word is picked
    spu_op_delay #(
        .LATENCY    (LANE_LATENCY),
        .data_t     (spu_op_t),
        .CLEAR_DATA (OP_NOR)
    ) u_tag (
        .clk     (clk),
        .rst     (rst),
        .cke     (cke),
        .s_data  (s_op),
        .s_clear (item_clear),
        .s_valid (s_valid),
        .m_data  (tag_op),
        .m_valid ()
    );

    // result select by tag
    always_comb begin
        if (tag_op == OP_ADD || tag_op == OP_SUB) begin
            m_data  = as_data;
            m_carry = as_carry;
        end else begin
            m_data  = logic_pad_data;
            m_carry = 1'b0;  // logic ops never carry
        end
    end

endmodule

`default_nettype wire

// ==== hw/spu_op_addsub.sv ====
`timescale 1ns/1ps
`default_nettype none

module spu_op_addsub (
    input  var logic           clk,
    input  var logic           rst,
    input  var logic           cke,

    input  var logic           s_sub,    // 1 selects data0 - data1
    input  var spu_pkg::data_t s_data0,
    input  var spu_pkg::data_t s_data1,
    input  var logic           s_clear,
    input  var logic           s_valid,

    output var spu_pkg::data_t m_data,
    output var logic           m_carry,
    output var logic           m_valid
);

    import spu_pkg::*;

    // carry sits above the sum word
    typedef struct packed {
        logic  carry;
        data_t data;
    } sum_t;

    data_t opnd1;
    sum_t  st1_sum;
    logic  st1_clear;
    logic  st1_valid;
    sum_t  out_sum;

    // subtract as data0 + ~data1 + 1, carry high means no borrow
    assign opnd1 = s_sub ? ~s_data1 : s_data1;

    always_ff @(posedge clk) begin
        if (rst) begin
            st1_sum   <= '0;
            st1_clear <= 1'b0;
            st1_valid <= 1'b0;
        end else if (cke) begin
            st1_sum   <= sum_t'({1'b0, s_data0} + {1'b0, opnd1} + (DATA_BITS + 1)'(s_sub));
            st1_clear <= s_clear;
            st1_valid <= s_valid;
        end
    end

    // remaining stages up to the lane latency
    spu_op_delay #(
        .LATENCY    (LANE_LATENCY - 1),
        .data_t     (sum_t),
        .CLEAR_DATA ('0)
    ) u_latency (
        .clk        (clk),
        .rst        (rst),
        .cke        (cke),
        .s_data     (st1_sum),
        .s_clear    (st1_clear),
        .s_valid    (st1_valid),
        .m_data     (out_sum),
        .m_valid    (m_valid)
    );

    assign m_data  = out_sum.data;
    assign m_carry = out_sum.carry;

endmodule

`default_nettype wire

// ==== hw/spu_op_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module spu_op_delay #(
    parameter int  LATENCY    = 1,                 // enabled cycles of delay
    parameter type data_t     = logic [15:0],      // payload type
    parameter data_t CLEAR_DATA = '0               // payload of a cleared item
) (
    input  var logic  clk,
    input  var logic  rst,
    input  var logic  cke,

    input  var data_t s_data,
    input  var logic  s_clear,
    input  var logic  s_valid,

    output var data_t m_data,
    output var logic  m_valid
);

    if (LATENCY == 0) begin : g_pass
        // no registers, clear applied on the fly
        assign m_data  = s_clear ? CLEAR_DATA : s_data;
        assign m_valid = s_valid;
    end else begin : g_pipe
        data_t stage_data  [LATENCY];
        logic  stage_valid [LATENCY];

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int i = 0; i < LATENCY; i++) begin
                    stage_data[i]  <= CLEAR_DATA;
                    stage_valid[i] <= 1'b0;
                end
            end else if (cke) begin  // whole chain frozen while cke low
                stage_data[0]  <= s_clear ? CLEAR_DATA : s_data;
                stage_valid[0] <= s_valid;
                for (int i = 1; i < LATENCY; i++) begin
                    stage_data[i]  <= stage_data[i-1];
                    stage_valid[i] <= stage_valid[i-1];
                end
            end
        end

        assign m_data  = stage_data[LATENCY-1];
        assign m_valid = stage_valid[LATENCY-1];
    end

endmodule

`default_nettype wire

// ==== hw/spu_op_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module spu_op_logic (
    input  var logic                clk,
    input  var logic                rst,
    input  var logic                cke,

    input  var spu_pkg::logic_func_t s_func,
    input  var spu_pkg::data_t      s_data0,
    input  var spu_pkg::data_t      s_data1,
    input  var logic                s_clear,
    input  var logic                s_valid,

    output var spu_pkg::data_t      m_data,
    output var logic                m_valid
);

    import spu_pkg::*;

    data_t st0_data;
    logic  st0_clear;
    logic  st0_valid;

    // bitwise result formed ahead of the delay line
    always_comb begin
        case (s_func)
            LF_NOR:  st0_data = ~(s_data0 | s_data1);
            LF_AND:  st0_data = s_data0 & s_data1;
            LF_OR:   st0_data = s_data0 | s_data1;
            default: st0_data = s_data0 ^ s_data1;  // LF_XOR
        endcase
    end

    assign st0_clear = s_clear;
    assign st0_valid = s_valid;

    spu_op_delay #(
        .LATENCY    (LOGIC_LATENCY),
        .data_t     (data_t),
        .CLEAR_DATA (CLEAR_WORD)
    ) u_latency (
        .clk        (clk),
        .rst        (rst),
        .cke        (cke),
        .s_data     (st0_data),
        .s_clear    (st0_clear),
        .s_valid    (st0_valid),
        .m_data     (m_data),
        .m_valid    (m_valid)
    );

endmodule

`default_nettype wire

// ==== hw/spu_pkg.sv ====
package spu_pkg;

    // word width of operands and results
    localparam int DATA_BITS = 16;

    typedef logic [DATA_BITS-1:0] data_t;

    // enabled cycles from accepted strobe to lane output
    localparam int LANE_LATENCY = 2;

    // logic operator depth, padded up inside the core
    localparam int LOGIC_LATENCY = 1;

    // lane operation codes, 6 and 7 left free
    typedef enum logic [2:0] {
        OP_NOR = 3'd0,
        OP_AND = 3'd1,
        OP_OR  = 3'd2,
        OP_XOR = 3'd3,
        OP_ADD = 3'd4,
        OP_SUB = 3'd5
    } spu_op_t;

    // function select of the bitwise operator
    typedef enum logic [1:0] {
        LF_NOR = 2'd0,
        LF_AND = 2'd1,
        LF_OR  = 2'd2,
        LF_XOR = 2'd3
    } logic_func_t;

    // result word of a cleared item
    localparam data_t CLEAR_WORD = '0;

endpackage

// ==== sources.f ====
hw/spu_pkg.sv
hw/spu_op_delay.sv
hw/spu_op_logic.sv
hw/spu_op_addsub.sv
hw/spu_core.sv
dv/spu_clk_gen.sv
dv/spu_asserts.sv
dv/spu_tb.sv
